// File: rtl/rename_cfg_pkg.sv
package rename_cfg_pkg;

   // ========================================
   // Architectural side of the rename map
   // ========================================

   localparam int AREGS  = 32;                // Registers visible to software
   localparam int AREG_W = $clog2(AREGS);     // 5 bits for an architectural number

   // ========================================
   // Physical side of the rename map
   // ========================================

   localparam int PREGS  = 128;               // Entries in the physical register file
   localparam int PREG_W = $clog2(PREGS);     // 7 bits for a physical number

   // One live map entry, also one element of a checkpoint row
   typedef logic [PREG_W-1:0] pregno_t;

   // Checkpoint slot number
   // Four bits caps the number of slots at 16
   localparam int SLOT_W = 4;

endpackage

// File: rtl/map_cmd_pkg.sv
package map_cmd_pkg;

   import rename_cfg_pkg::*;

   // ========================================
   // Host bus geometry and address map
   // ========================================

   localparam int WB_DW = 32;                 // Bus data width
   localparam int WB_AW = 6;                  // Word address width

   // Words 0 to 31 read the live map, word 32 takes commands
   localparam logic [WB_AW-1:0] CMD_ADDR = 6'd32;

   // Command opcodes, always in the top two bits of the word
   typedef enum logic [1:0] {
      OP_NOP       = 2'd0,                    // Accepted and dropped
      OP_MAP_WRITE = 2'd1,                    // Set one live entry
      OP_SAVE      = 2'd2,                    // Live map into a slot
      OP_RESTORE   = 2'd3                     // Slot back into the live map
   } map_op_t;

   // The same command word seen two ways
   // The map view carries a register pair, the checkpoint view a slot number
   typedef union packed {
      struct packed {
         map_op_t                op;
         logic [WB_DW-3-AREG_W-PREG_W:0] rsvd;
         logic [AREG_W-1:0]      areg;        // Architectural register to remap
         pregno_t                preg;        // New physical register for it
      } map;
      struct packed {
         map_op_t                op;
         logic [WB_DW-3-SLOT_W:0] rsvd;
         logic [SLOT_W-1:0]      slot;        // Checkpoint slot to save or restore
      } ckpt;
   } cmd_word_u;

endpackage

// File: rtl/map_bus_slave.sv
`timescale 1ns/1ps

module map_bus_slave import rename_cfg_pkg::*, map_cmd_pkg::*; #(
   parameter int NCHECK = 16,
   parameter int NBANKS = 4
) (
   input  logic                  clka,
   input  logic                  reset,
   input  logic                  wb_cyc,
   input  logic                  wb_stb,
   input  logic                  wb_we,
   input  logic [WB_AW-1:0]      wb_adr,
   input  logic [WB_DW-1:0]      wb_dat_w,
   output logic                  wb_ack,
   output logic [NBANKS-1:0]     map_we,       // One-hot, the owning bank only
   output logic [$clog2(AREGS/NBANKS)-1:0] map_idx,
   output pregno_t               map_preg,
   output logic                  save,
   output logic                  restore,
   output logic [SLOT_W-1:0]     slot,
   output logic [$clog2(AREGS/NBANKS)-1:0] rd_idx,
   output logic [$clog2(NBANKS)-1:0] rd_bank,
   output logic                  rd_valid
);

   localparam int BANK_SZ = AREGS / NBANKS;     // Architectural registers per bank
   localparam int IDX_W   = $clog2(BANK_SZ);    // Low bits of a register number
   localparam int BANK_W  = $clog2(NBANKS);     // High bits pick the bank

   // ========================================
   // Request qualification
   // ========================================

   logic              req;                      // New request, not yet acknowledged
   logic              cmd_wr;                   // Write aimed at the command word
   logic              map_hit;                  // Address falls in the live map window
   logic              slot_ok;                  // Slot exists in this build
   cmd_word_u         cmd;
   logic [BANK_W-1:0] wr_bank;
   logic [IDX_W-1:0]  wr_idx;

   assign req     = wb_cyc & wb_stb & ~wb_ack;  // Ack high means this cycle is already served
   assign cmd_wr  = req & wb_we & (wb_adr == CMD_ADDR);
   assign map_hit = int'(wb_adr) < AREGS;

   assign cmd     = cmd_word_u'(wb_dat_w);      // One word, decoded per opcode below
   assign wr_idx  = cmd.map.areg[IDX_W-1:0];
   assign wr_bank = cmd.map.areg[IDX_W +: BANK_W];
   assign slot_ok = int'(cmd.ckpt.slot) < NCHECK;

   // Reads go straight to the banks so the readback can capture at the ack edge
   assign rd_idx   = wb_adr[IDX_W-1:0];
   assign rd_bank  = wb_adr[IDX_W +: BANK_W];
   assign rd_valid = req & ~wb_we & map_hit;

   // ========================================
   // Registered handshake and strobes
   // ========================================

   always_ff @(posedge clka) begin
      if (reset) begin
         wb_ack  <= 1'b0;
         map_we  <= '0;
         save    <= 1'b0;
         restore <= 1'b0;
      end else begin
         wb_ack  <= req;                         // Every address gets acknowledged
         map_we  <= '0;                          // Strobes last one cycle
         save    <= 1'b0;
         restore <= 1'b0;
         if (cmd_wr) begin
            case (cmd.map.op)
               OP_MAP_WRITE: map_we  <= NBANKS'(1) << wr_bank;
               OP_SAVE:      save    <= slot_ok;   // A missing slot turns into a no-op
               OP_RESTORE:   restore <= slot_ok;
               default: ;                          // NOP
            endcase
         end
      end
   end

   // Command payload rides along with the strobes
   always_ff @(posedge clka) begin
      if (cmd_wr) begin
         map_idx  <= wr_idx;
         map_preg <= cmd.map.preg;
         slot     <= cmd.ckpt.slot;
      end
   end

   // Ack only follows a cycle where the host was really asking
   ack_needs_req: assert property (@(posedge clka) disable iff (reset)
      $rose(wb_ack) |-> $past(wb_cyc & wb_stb));

   // The banks rely on a single operation per cycle
   one_op_at_a_time: assert property (@(posedge clka) disable iff (reset)
      $onehot0({map_we, save, restore}));

endmodule

// File: rtl/checkpoint_bank.sv
`timescale 1ns/1ps

module checkpoint_bank import rename_cfg_pkg::*; #(
   parameter int NCHECK = 16,
   parameter int NBANKS = 4
) (
   input  logic                  clka,
   input  logic                  reset,
   input  logic                  map_we,
   input  logic [$clog2(AREGS/NBANKS)-1:0] map_idx,
   input  pregno_t               map_preg,
   input  logic                  save,
   input  logic                  restore,
   input  logic [SLOT_W-1:0]     slot,
   input  logic [$clog2(AREGS/NBANKS)-1:0] rd_idx,
   input  logic [$clog2(NBANKS)-1:0] bank_id,   // Position in the generate loop
   output pregno_t               entry_out
);

   localparam int BANK_SZ = AREGS / NBANKS;
   localparam int IDX_W   = $clog2(BANK_SZ);

   // ========================================
   // Live entries and checkpoint rows
   // ========================================

   pregno_t [BANK_SZ-1:0] live;                 // This bank's slice of the live map
   pregno_t [BANK_SZ-1:0] mem [NCHECK];         // One row per slot, distributed RAM
   pregno_t [BANK_SZ-1:0] ckpt_row;             // Asynchronous read of the chosen slot

   // Slots start out as all zero, they are never reset afterwards
   initial begin
      for (int n = 0; n < NCHECK; n++) begin
         mem[n] = '0;
      end
   end

   assign ckpt_row = mem[slot];

   // Save samples the live slice before any update at the same edge
   always_ff @(posedge clka) begin
      if (save) begin
         mem[slot] <= live;
      end
   end

   always_ff @(posedge clka) begin
      if (reset) begin
         // Identity map, so entry i of bank b holds b * BANK_SZ + i
         for (int i = 0; i < BANK_SZ; i++) begin
            live[i] <= PREG_W'({bank_id, IDX_W'(i)});
         end
      end else if (restore) begin
         live <= ckpt_row;                       // Whole slice in one step
      end else if (map_we) begin
         live[map_idx] <= map_preg;
      end
   end

   assign entry_out = live[rd_idx];             // Read port for the host

   // The slave filters slot numbers, the RAM has no row past NCHECK
   slot_in_range: assert property (@(posedge clka) disable iff (reset)
      (save | restore) |-> int'(slot) < NCHECK);

endmodule

// File: rtl/map_readback.sv
`timescale 1ns/1ps

module map_readback import rename_cfg_pkg::*, map_cmd_pkg::*; #(
   parameter int NBANKS = 4
) (
   input  logic                      clka,
   input  logic                      reset,
   input  logic [NBANKS*PREG_W-1:0]  entries,  // entry_out of every bank, bank 0 lowest
   input  logic [$clog2(NBANKS)-1:0] rd_bank,
   input  logic                      rd_valid,
   output logic [WB_DW-1:0]          wb_dat_r
);

   pregno_t sel_entry;                          // Entry of the addressed bank

   // The bank already picked its entry by rd_idx, here only the bank is chosen
   assign sel_entry = entries[rd_bank*PREG_W +: PREG_W];

   // ========================================
   // Read data register
   // ========================================

   // Captured at the edge that raises ack, so data and ack line up
   always_ff @(posedge clka) begin
      if (reset) begin
         wb_dat_r <= '0;
      end else if (rd_valid) begin
         wb_dat_r <= WB_DW'(sel_entry);         // Zero extended to the bus width
      end else begin
         wb_dat_r <= '0;                        // Command word and unused words read as zero
      end
   end

endmodule

// File: rtl/rename_ckpt_top.sv
`timescale 1ns/1ps

module rename_ckpt_top import rename_cfg_pkg::*, map_cmd_pkg::*; #(
   parameter int NCHECK = 16,                   // Checkpoint slots
   parameter int NBANKS = 4                     // Banks the map is split into
) (
   input  logic              clka,
   input  logic              reset,
   input  logic              wb_cyc,
   input  logic              wb_stb,
   input  logic              wb_we,
   input  logic [WB_AW-1:0]  wb_adr,
   input  logic [WB_DW-1:0]  wb_dat_w,
   output logic              wb_ack,
   output logic [WB_DW-1:0]  wb_dat_r
);

   localparam int BANK_SZ = AREGS / NBANKS;
   localparam int IDX_W   = $clog2(BANK_SZ);
   localparam int BANK_W  = $clog2(NBANKS);

   // ========================================
   // Slave to bank and readback wiring
   // ========================================

   logic [NBANKS-1:0]        map_we;
   logic [IDX_W-1:0]         map_idx;
   pregno_t                  map_preg;
   logic                     save;
   logic                     restore;
   logic [SLOT_W-1:0]        slot;
   logic [IDX_W-1:0]         rd_idx;
   logic [BANK_W-1:0]        rd_bank;
   logic                     rd_valid;
   logic [NBANKS*PREG_W-1:0] entries;           // Gathered entry_out of all banks

   map_bus_slave #(.NCHECK(NCHECK), .NBANKS(NBANKS)) u_map_bus_slave (
      .clka     (clka),
      .reset    (reset),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_w (wb_dat_w),
      .wb_ack   (wb_ack),
      .map_we   (map_we),
      .map_idx  (map_idx),
      .map_preg (map_preg),
      .save     (save),
      .restore  (restore),
      .slot     (slot),
      .rd_idx   (rd_idx),
      .rd_bank  (rd_bank),
      .rd_valid (rd_valid)
   );

   // Checkpoint operations reach every bank, map writes only the owner
   for (genvar g = 0; g < NBANKS; g++) begin : g_bank
      checkpoint_bank #(.NCHECK(NCHECK), .NBANKS(NBANKS)) u_checkpoint_bank (
         .clka      (clka),
         .reset     (reset),
         .map_we    (map_we[g]),
         .map_idx   (map_idx),
         .map_preg  (map_preg),
         .save      (save),
         .restore   (restore),
         .slot      (slot),
         .rd_idx    (rd_idx),
         .bank_id   (BANK_W'(g)),              // Sets the bank's identity values
         .entry_out (entries[g*PREG_W +: PREG_W])
      );
   end

   map_readback #(.NBANKS(NBANKS)) u_map_readback (
      .clka     (clka),
      .reset    (reset),
      .entries  (entries),
      .rd_bank  (rd_bank),
      .rd_valid (rd_valid),
      .wb_dat_r (wb_dat_r)
   );

endmodule

// File: sim/clk_gen.sv
`timescale 1ns/1ps

module clk_gen #(
   parameter int PERIOD_NS = 8                  // Full clock period in ns
) (
   output logic clka
);

   // Free running clock, low for the first half period
   initial begin
      clka = 1'b0;
      forever #(PERIOD_NS / 2) clka = ~clka;
   end

endmodule

// File: sim/tb_rename_ckpt.sv
`timescale 1ns/1ps

module tb_rename_ckpt;

   localparam int AREGS    = 32;                // Architectural registers in the map
   localparam int NCHECK   = 16;                // Checkpoint slots in the DUT
   localparam int CMD_ADDR = 32;                // Word address of the command register
   localparam int ACK_WAIT = 20;                // Cycles an access may wait for ack

   logic        clka;
   logic        reset;
   logic        wb_cyc;
   logic        wb_stb;
   logic        wb_we;
   logic [5:0]  wb_adr;
   logic [31:0] wb_dat_w;
   logic        wb_ack;
   logic [31:0] wb_dat_r;

   int          seed = 68307;
   int          errors;                         // Errors of the running test
   int          total_errors;
   int          checks;
   int          tests_run;
   int          tests_failed;
   string       test_name;

   // Reference model of the live map and the checkpoint slots
   logic [6:0]  model_map [AREGS];
   logic [6:0]  model_slot [NCHECK][AREGS];

   clk_gen u_clk_gen (.clka(clka));

   rename_ckpt_top u_rename_ckpt_top (
      .clka     (clka),
      .reset    (reset),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_w (wb_dat_w),
      .wb_ack   (wb_ack),
      .wb_dat_r (wb_dat_r)
   );

   // ========================================
   // Bus access and model helpers
   // ========================================

   // One Wishbone classic access, inputs change 1 ns after the rising edge
   task automatic bus_access(input logic we, input int adr, input logic [31:0] wdata,
                             output logic [31:0] rdata);
      int n;
      @(posedge clka);
      #1;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = 6'(adr);
      wb_dat_w = wdata;
      n = 0;
      do begin
         @(posedge clka);
         #1;                                    // Ack and read data settled since the edge
         n++;
      end while (!wb_ack && n < ACK_WAIT);
      rdata  = wb_dat_r;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
      if (!wb_ack) begin
         $display("Access to address %0d got no ack within %0d cycles", adr, ACK_WAIT);
         $display("** FAIL **");
         $finish;
      end else begin
         @(posedge clka);
         #1;
         assert (!wb_ack) else begin            // Ack is a single cycle pulse
            $display("Access to address %0d was acknowledged more than once", adr);
            errors++;
         end
      end
   endtask

   // Value a read should return according to the address map
   function automatic int expected_read(input int adr);
      if (adr < AREGS) return int'(model_map[adr]);
      return 0;                                 // Command word and unused words
   endfunction

   task automatic check_read(input int adr);
      logic [31:0] data;
      int          exp;
      exp = expected_read(adr);
      bus_access(1'b0, adr, 32'h0, data);
      checks++;
      assert (data == 32'(exp)) else begin
         $display("** Error %s at address %0d: expected %0d, actual %0d",
                  test_name, adr, exp, data);
         errors++;
      end
   endtask

   // Command fields from the top: op 31:30, areg 11:7, preg 6:0, slot 3:0
   function automatic void apply_cmd(input logic [31:0] word);
      int s;
      s = int'(word[3:0]);
      case (word[31:30])
         2'd1: model_map[word[11:7]] = word[6:0];
         2'd2: if (s < NCHECK) for (int i = 0; i < AREGS; i++) model_slot[s][i] = model_map[i];
         2'd3: if (s < NCHECK) for (int i = 0; i < AREGS; i++) model_map[i] = model_slot[s][i];
         default: ;                             // NOP leaves everything alone
      endcase
   endfunction

   task automatic send_cmd(input logic [31:0] word);
      logic [31:0] unused;
      bus_access(1'b1, CMD_ADDR, word, unused);
      apply_cmd(word);
   endtask

   function automatic logic [31:0] map_cmd(input int areg, input int preg);
      return {2'd1, 18'd0, 5'(areg), 7'(preg)};
   endfunction

   function automatic logic [31:0] ckpt_cmd(input logic [1:0] op, input int slot);
      return {op, 26'd0, 4'(slot)};
   endfunction

   task automatic random_map_writes(input int count);
      for (int k = 0; k < count; k++) begin
         send_cmd(map_cmd($random(seed) & 31, $random(seed) & 127));
      end
   endtask

   task automatic start_test(input string name);
      test_name = name;
      errors = 0;
   endtask

   task automatic end_test();
      tests_run++;
      total_errors += errors;
      if (errors == 0) begin
         $display("Test %s: passed", test_name);
      end else begin
         $display("Test %s: failed with %0d errors", test_name, errors);
         tests_failed++;
      end
   endtask

   // ========================================
   // Test sequence
   // ========================================

   initial begin
      int          adr;
      int          base;
      logic [31:0] dummy;
      reset    = 1'b1;
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      wb_we    = 1'b0;
      wb_adr   = '0;
      wb_dat_w = '0;
      for (int i = 0; i < AREGS; i++) begin
         model_map[i] = 7'(i);                  // Identity map after reset
         for (int s = 0; s < NCHECK; s++) model_slot[s][i] = '0;
      end
      repeat (5) @(posedge clka);
      #1;
      reset = 1'b0;

      start_test("reset_map");
      for (int i = 0; i < AREGS; i++) check_read(i);
      end_test();

      start_test("map_writes");
      for (int k = 0; k < 200; k++) begin
         random_map_writes(1);
         check_read($random(seed) & 31);
      end
      end_test();

      // Runs before any save so the chosen slot still holds zeros
      start_test("unsaved_slot");
      send_cmd(ckpt_cmd(2'd3, $random(seed) & 15));
      for (int i = 0; i < AREGS; i++) check_read(i);
      end_test();

      start_test("save_restore");
      base = $random(seed) & 15;
      for (int k = 0; k < NCHECK; k++) begin
         adr = (base + 7 * k) & 15;             // Stride 7 visits every slot once
         random_map_writes(4);
         send_cmd(ckpt_cmd(2'd2, adr));
         random_map_writes(8);                  // Corrupt the live map
         send_cmd(ckpt_cmd(2'd3, adr));
         for (int i = 0; i < AREGS; i++) check_read(i);
      end
      end_test();

      start_test("unmapped_addresses");
      for (int a = CMD_ADDR; a < 64; a++) check_read(a);
      for (int k = 0; k < 16; k++) begin
         adr = $random(seed) & 63;
         if (adr == CMD_ADDR) adr = 0;
         bus_access(1'b1, adr, $random(seed), dummy);
      end
      for (int i = 0; i < AREGS; i++) check_read(i);
      end_test();

      start_test("mixed_traffic");
      for (int k = 0; k < 500; k++) begin
         send_cmd($random(seed));               // Every opcode and random reserved bits
         check_read($random(seed) & 63);
      end
      end_test();

      $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, checks, total_errors);
      if (total_errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

// File: rename_ckpt.f
rtl/rename_cfg_pkg.sv
rtl/map_cmd_pkg.sv
rtl/map_bus_slave.sv
rtl/checkpoint_bank.sv
rtl/map_readback.sv
rtl/rename_ckpt_top.sv
sim/clk_gen.sv
sim/tb_rename_ckpt.sv

// File: Makefile
# Verilator build and run for the rename checkpoint unit

VERILATOR ?= verilator
TOP       ?= tb_rename_ckpt
FILELIST  ?= rename_ckpt.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= ** PASS **

SOURCES   := $(shell grep -v '^+' $(FILELIST))
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
